//--- rtl/cpc_loader_defines.svh
// Common widths, ROM page numbers and queue sizing for the CPC boot loader
`ifndef CPC_LOADER_DEFINES_SVH
`define CPC_LOADER_DEFINES_SVH

////////////////////
// Bus widths
`define CPC_DL_ADDR_W   25    // Host file address
`define CPC_MEM_ADDR_W  23    // 8 MB per bank
`define CPC_PAGE_OFS_W  14    // 16 KB page
`define CPC_PAGE_W      9
`define CPC_BANK_W      2
`define CPC_MAP_W       256   // One bit per upper-half page

`define CPC_QUEUE_DEPTH 4

////////////////////
// Pages of the base ROM slots
`define CPC_PAGE_OS     9'h000
`define CPC_PAGE_BASIC  9'h100
`define CPC_PAGE_AMSDOS 9'h107
`define CPC_PAGE_MF2    9'h0FF

`define CPC_PAGE_BAD_EXT    9'h1EE  // Spare page for malformed extensions
`define CPC_PAGE_COMBO_NEXT 9'h1FF  // Wraps to upper page 00 on the next block

// Special two-letter extensions
`define CPC_EXT_ZZ 16'h5A5A  // "ZZ"
`define CPC_EXT_Z0 16'h5A30  // "Z0"

`endif

//--- rtl/loader_pkg.sv
// Download-side types and producer FSM states of the boot loader
`default_nettype none

`include "cpc_loader_defines.svh"

package loader_pkg;

	typedef logic [`CPC_DL_ADDR_W-1:0] dl_addr_t;  // Byte address in the image file
	typedef logic [7:0]                dl_index_t; // Image index from the host
	typedef logic [15:0]               file_ext_t; // Two extension characters

	// Top bit picks the upper 4 MB half
	typedef logic [`CPC_PAGE_W-1:0] page_t;

	// Producer FSM
	typedef enum logic [1:0] {
		idle,
		emit,      // First or only copy
		emit_dual  // Copy into bank 1
	} loader_state_e;

endpackage

`default_nettype wire

//--- rtl/mem_pkg.sv
// Memory-side types and write port FSM states of the boot loader
`default_nettype none

`include "cpc_loader_defines.svh"

package mem_pkg;

	typedef logic [7:0]                 byte_t;
	typedef logic [`CPC_MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`CPC_BANK_W-1:0]     bank_t;     // 0 is 6128, 1 is 664
	typedef logic [`CPC_MAP_W-1:0]      rom_map_t;

	// Four-phase req/ack sequencing
	typedef enum logic [1:0] {idle, req_high, wait_ack_low} port_state_e;

endpackage

`default_nettype wire

//--- rtl/rom_image_loader.sv
// Maps host download bytes of ROM images to bank and address and queues the writes
`default_nettype none

`include "cpc_loader_defines.svh"

module rom_image_loader (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        ioctl_download,
	input  wire loader_pkg::dl_index_t ioctl_index,
	input  wire loader_pkg::file_ext_t ioctl_file_ext,
	input  wire loader_pkg::dl_addr_t  ioctl_addr,
	input  wire mem_pkg::byte_t        ioctl_dout,
	input  wire                        ioctl_wr,
	input  wire                        full,
	output logic                       ioctl_wait,
	output logic                       push,
	output mem_pkg::mem_addr_t         push_addr,
	output mem_pkg::bank_t             push_bank,
	output mem_pkg::byte_t             push_data
);

	localparam int SLOT_W = `CPC_DL_ADDR_W - `CPC_PAGE_OFS_W;

	loader_pkg::loader_state_e state;
	loader_pkg::page_t         page;       // Expansion base page
	loader_pkg::page_t         base_page;
	loader_pkg::page_t         start_page;
	logic                      combo;      // Z0 image switches page after the first 16 KB
	logic                      start_combo;
	logic                      dual;       // Bank 1 copy still to go
	logic                      download_d;
	logic                      rom_download;
	logic                      dl_start;
	logic                      accept;
	logic                      last_push;
	logic [SLOT_W-1:0]         slot;
	logic [7:0]                exp_page_lo;
	logic [4:0]                ext_hi;
	logic [4:0]                ext_lo;
	mem_pkg::mem_addr_t        next_addr;
	mem_pkg::bank_t            next_bank;

	// {valid, value} of an extension character taken as a hex digit
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_download = ioctl_download && (ioctl_index[4:0] < 5'd4);
	assign dl_start     = rom_download && !download_d;
	assign slot         = ioctl_addr[`CPC_DL_ADDR_W-1:`CPC_PAGE_OFS_W];
	assign exp_page_lo  = page[7:0] + ioctl_addr[21:14];  // Wraps mod 256
	assign ext_hi       = hex_digit(ioctl_file_ext[15:8]);
	assign ext_lo       = hex_digit(ioctl_file_ext[7:0]);

	////////////////////
	// Address mapping

	always_comb begin
		case (slot[1:0])
			2'd0:    base_page = `CPC_PAGE_OS;
			2'd1:    base_page = `CPC_PAGE_BASIC;
			2'd2:    base_page = `CPC_PAGE_AMSDOS;
			default: base_page = `CPC_PAGE_MF2;
		endcase

		if (ioctl_index != '0) begin
			next_addr = {page[8], exp_page_lo, ioctl_addr[`CPC_PAGE_OFS_W-1:0]};
			next_bank = {1'b0, &ioctl_index[7:6]};
		end else begin
			next_addr = {base_page, ioctl_addr[`CPC_PAGE_OFS_W-1:0]};
			next_bank = {1'b0, slot[2]};                 // Slots 4..7 go to the 664
		end
	end

	// Page picked from the extension at download start
	always_comb begin
		start_page  = `CPC_PAGE_BAD_EXT;
		start_combo = 1'b0;
		if (ext_hi[4]) start_page[7:4] = ext_hi[3:0];
		if (ext_lo[4]) start_page[3:0] = ext_lo[3:0];
		if (ioctl_file_ext == `CPC_EXT_ZZ) start_page = '0;
		if (ioctl_file_ext == `CPC_EXT_Z0) begin
			start_page  = '0;
			start_combo = 1'b1;
		end
	end

	// Base image bytes past slot 7 are dropped
	assign accept    = (state == loader_pkg::idle) && rom_download && ioctl_wr &&
		(ioctl_index != '0 || slot < SLOT_W'(8));
	assign push      = (state != loader_pkg::idle);
	assign last_push = push && !full && (state == loader_pkg::emit_dual || !dual);

	////////////////////
	// Control

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= loader_pkg::idle;
			ioctl_wait <= 1'b0;
			dual       <= 1'b0;
			combo      <= 1'b0;
			page       <= '0;
			download_d <= 1'b0;
		end else begin
			download_d <= ioctl_download;

			if (accept) begin
				state      <= loader_pkg::emit;
				ioctl_wait <= 1'b1;
				dual       <= (ioctl_index[7:6] == 2'b01 || ioctl_index[5:0] != '0) &&
					next_bank == '0;
			end else if (state == loader_pkg::emit && !full && dual) begin
				state <= loader_pkg::emit_dual;
				dual  <= 1'b0;
			end

			if (last_push) begin
				state      <= loader_pkg::idle;
				ioctl_wait <= 1'b0;
				if (combo && &push_addr[`CPC_PAGE_OFS_W-1:0]) begin
					combo <= 1'b0;
					page  <= `CPC_PAGE_COMBO_NEXT;
				end
			end

			if (dl_start && ioctl_index != '0) begin
				page  <= start_page;
				combo <= start_combo;
			end
		end
	end

	// Write payload and the bank flip for the second copy
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			push_addr <= next_addr;
			push_bank <= next_bank;
			push_data <= ioctl_dout;
		end else if (state == loader_pkg::emit && !full && dual) begin
			push_bank <= 2'd1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/write_queue.sv
// Circular FIFO of pending memory writes between the loader and the memory port
`default_nettype none

`include "cpc_loader_defines.svh"

module write_queue (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     push,
	input  wire mem_pkg::mem_addr_t push_addr,
	input  wire mem_pkg::bank_t     push_bank,
	input  wire mem_pkg::byte_t     push_data,
	input  wire                     pop,
	output logic                    full,
	output logic                    empty,
	output mem_pkg::mem_addr_t      head_addr,
	output mem_pkg::bank_t          head_bank,
	output mem_pkg::byte_t          head_data
);

	localparam int DEPTH = `CPC_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_pkg::mem_addr_t addr_mem [DEPTH];
	mem_pkg::bank_t     bank_mem [DEPTH];
	mem_pkg::byte_t     data_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Pointer step with wrap at the last entry
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	assign head_addr = addr_mem[rd_ptr];
	assign head_bank = bank_mem[rd_ptr];
	assign head_data = data_mem[rd_ptr];

	////////////////////
	// Storage

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			addr_mem[wr_ptr] <= push_addr;
			bank_mem[wr_ptr] <= push_bank;
			data_mem[wr_ptr] <= push_data;
		end
	end

	// Pointers and fill level
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)  rd_ptr <= next_ptr(rd_ptr);

			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;      // Push and pop together keep the level
		end
	end

endmodule

`default_nettype wire

//--- rtl/bank_write_port.sv
// Memory write port with four-phase req/ack and the map of loaded expansion pages
`default_nettype none

`include "cpc_loader_defines.svh"

module bank_write_port (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     empty,
	input  wire mem_pkg::mem_addr_t head_addr,
	input  wire mem_pkg::bank_t     head_bank,
	input  wire mem_pkg::byte_t     head_data,
	input  wire                     mem_ack,
	output logic                    pop,
	output logic                    mem_req,
	output mem_pkg::mem_addr_t      mem_addr,
	output mem_pkg::bank_t          mem_bank,
	output mem_pkg::byte_t          mem_data,
	output mem_pkg::rom_map_t       rom_map
);

	localparam int HI_BIT = `CPC_MEM_ADDR_W - 1;

	mem_pkg::port_state_e state;
	logic                 write_done;

	// Next entry only once the previous ack is gone
	assign pop = (state == mem_pkg::idle) && !empty && !mem_ack;

	assign mem_req    = (state == mem_pkg::req_high);
	assign write_done = (state == mem_pkg::wait_ack_low) && !mem_ack;

	////////////////////
	// Handshake FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= mem_pkg::idle;
		end else begin
			case (state)
				mem_pkg::idle:
					if (pop) state <= mem_pkg::req_high;
				mem_pkg::req_high:
					if (mem_ack) state <= mem_pkg::wait_ack_low;  // Drop req
				mem_pkg::wait_ack_low:
					if (!mem_ack) state <= mem_pkg::idle;
				default:
					state <= mem_pkg::idle;
			endcase
		end
	end

	// Held from the rise of req until it falls
	always_ff @(posedge clk_sys) begin
		if (pop) begin
			mem_addr <= head_addr;
			mem_bank <= head_bank;
			mem_data <= head_data;
		end
	end

	////////////////////
	// Loaded page map

	// Upper-half writes mark their page within that half
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_map <= '0;
		end else if (write_done && mem_addr[HI_BIT]) begin
			rom_map[mem_addr[HI_BIT-1 -: 8]] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cpc_loader_top.sv
// Boot loader top level joining the ROM image mapper, write queue and memory write port
`default_nettype none

module cpc_loader_top (
	input  wire                        clk_sys,
	input  wire                        reset,

	// Host download
	input  wire                        ioctl_download,
	input  wire loader_pkg::dl_index_t ioctl_index,
	input  wire loader_pkg::file_ext_t ioctl_file_ext,
	input  wire loader_pkg::dl_addr_t  ioctl_addr,
	input  wire mem_pkg::byte_t        ioctl_dout,
	input  wire                        ioctl_wr,
	output wire                        ioctl_wait,

	// External memory
	output wire                        mem_req,
	output wire mem_pkg::mem_addr_t    mem_addr,
	output wire mem_pkg::bank_t        mem_bank,
	output wire mem_pkg::byte_t        mem_data,
	input  wire                        mem_ack,

	output wire mem_pkg::rom_map_t     rom_map
);

	// Loader to queue
	wire                     push;
	wire mem_pkg::mem_addr_t push_addr;
	wire mem_pkg::bank_t     push_bank;
	wire mem_pkg::byte_t     push_data;
	wire                     full;

	// Queue to write port
	wire                     pop;
	wire                     empty;
	wire mem_pkg::mem_addr_t head_addr;
	wire mem_pkg::bank_t     head_bank;
	wire mem_pkg::byte_t     head_data;

	rom_image_loader i_loader (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr), .full(full),
		.ioctl_wait(ioctl_wait), .push(push), .push_addr(push_addr),
		.push_bank(push_bank), .push_data(push_data)
	);

	write_queue i_queue (
		.clk_sys(clk_sys), .reset(reset), .push(push), .push_addr(push_addr),
		.push_bank(push_bank), .push_data(push_data), .pop(pop), .full(full),
		.empty(empty), .head_addr(head_addr), .head_bank(head_bank), .head_data(head_data)
	);

	bank_write_port i_port (
		.clk_sys(clk_sys), .reset(reset), .empty(empty), .head_addr(head_addr),
		.head_bank(head_bank), .head_data(head_data), .mem_ack(mem_ack), .pop(pop),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_bank(mem_bank),
		.mem_data(mem_data), .rom_map(rom_map)
	);

endmodule

`default_nettype wire

//--- testbench/cpc_loader_assertions.sv
// Bound checks of the memory req/ack handshake and the host download wait
`default_nettype none

module cpc_loader_assertions (
	input wire                     clk_sys,
	input wire                     reset,
	input wire                     ioctl_wr,
	input wire                     ioctl_wait,
	input wire                     mem_req,
	input wire                     mem_ack,
	input wire mem_pkg::mem_addr_t mem_addr,
	input wire mem_pkg::bank_t     mem_bank,
	input wire mem_pkg::byte_t     mem_data
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////
	// Memory handshake

	req_held_until_ack: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack was seen");

	// Address, bank and data frozen for the whole request
	payload_stable: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req |=> !mem_req || $stable({mem_addr, mem_bank, mem_data}))
		else $error("memory write payload changed while mem_req was high");

	req_rise_ack_low: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem_req) |-> !$past(mem_ack))
		else $error("mem_req rose while mem_ack was still high");

	// Wait rises only in the cycle after a host strobe
	wait_after_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ioctl_wait) |-> $past(ioctl_wr))
		else $error("ioctl_wait rose without a preceding ioctl_wr strobe");

endmodule

bind cpc_loader_top cpc_loader_assertions i_assertions (
	.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr), .ioctl_wait(ioctl_wait),
	.mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr), .mem_bank(mem_bank),
	.mem_data(mem_data)
);

`default_nettype wire

//--- testbench/tb_cpc_loader.sv
// Testbench of the CPC boot loader with file-driven downloads and a slow memory model
`default_nettype none

`include "cpc_loader_defines.svh"

module tb_cpc_loader;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_RECORDS = 64;

	logic                  clk_sys;
	logic                  reset;
	logic                  ioctl_download;
	loader_pkg::dl_index_t ioctl_index;
	loader_pkg::file_ext_t ioctl_file_ext;
	loader_pkg::dl_addr_t  ioctl_addr;
	mem_pkg::byte_t        ioctl_dout;
	logic                  ioctl_wr;
	logic                  ioctl_wait;
	logic                  mem_req;
	mem_pkg::mem_addr_t    mem_addr;
	mem_pkg::bank_t        mem_bank;
	mem_pkg::byte_t        mem_data;
	logic                  mem_ack;
	mem_pkg::rom_map_t     rom_map;

	logic [47:0]       records [MAX_RECORDS];  // kind, 28-bit field a, 16-bit field b
	logic [32:0]       expected_q [$];         // {bank, address, data}
	mem_pkg::rom_map_t expected_map = '0;
	loader_pkg::page_t model_page = '0;
	logic              model_combo = 1'b0;
	string             test_name = "after reset";
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int writes_expected = 0;
	int writes_done = 0;
	int ack_min = 0;
	int ack_max = 0;
	int wait_run = 0;
	int stalls = 0;
	int stalls_at_start = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	int num_records = 0;
	integer seed = 32'hddfc9a71;

	cpc_loader_top i_dut (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_file_ext(ioctl_file_ext), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr), .ioctl_wait(ioctl_wait),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_bank(mem_bank), .mem_data(mem_data),
		.mem_ack(mem_ack), .rom_map(rom_map)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_test;
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	////////////////////
	// Reference model

	// {valid, value} of one extension character read as a hex digit
	function automatic logic [4:0] ext_nibble(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b1, 4'(c - 8'h37)};
		return 5'd0;
	endfunction

	task automatic model_start(input loader_pkg::dl_index_t idx,
		input loader_pkg::file_ext_t ext);
		logic [4:0] hi;
		logic [4:0] lo;
		hi = ext_nibble(ext[15:8]);
		lo = ext_nibble(ext[7:0]);
		if (idx == 8'd0 || idx[4:0] >= 5'd4)
			return;                                   // Base image keeps its fixed pages
		model_page  = `CPC_PAGE_BAD_EXT;
		model_combo = 1'b0;
		if (hi[4])
			model_page[7:4] = hi[3:0];
		if (lo[4])
			model_page[3:0] = lo[3:0];
		if (ext == "ZZ")
			model_page = 9'h000;
		if (ext == "Z0") begin
			model_page  = 9'h000;
			model_combo = 1'b1;
		end
	endtask

	task automatic expect_write(input mem_pkg::bank_t bank, input mem_pkg::mem_addr_t addr,
		input mem_pkg::byte_t data);
		expected_q.push_back({bank, addr, data});
		writes_expected++;
		if (addr[22])
			expected_map[addr[21:14]] = 1'b1;
	endtask

	task automatic model_byte(input loader_pkg::dl_addr_t addr, input mem_pkg::byte_t data);
		logic [10:0]        slot;
		logic [13:0]        ofs;
		loader_pkg::page_t  pg;
		mem_pkg::mem_addr_t a;
		mem_pkg::bank_t     bank;
		slot = addr[24:14];
		ofs  = addr[13:0];
		if (ioctl_index[4:0] >= 5'd4)
			return;
		if (ioctl_index == 8'd0) begin
			if (slot >= 11'd8)
				return;
			case (slot[1:0])
				2'd0:    pg = `CPC_PAGE_OS;
				2'd1:    pg = `CPC_PAGE_BASIC;
				2'd2:    pg = `CPC_PAGE_AMSDOS;
				default: pg = `CPC_PAGE_MF2;
			endcase
			expect_write({1'b0, slot[2]}, {pg, ofs}, data);   // 664 from slot 4 up
		end else begin
			a    = {model_page[8], model_page[7:0] + addr[21:14], ofs};
			bank = {1'b0, &ioctl_index[7:6]};
			expect_write(bank, a, data);
			if ((ioctl_index[7:6] == 2'b01 || ioctl_index[5:0] != 6'd0) && bank == 2'd0)
				expect_write(2'd1, a, data);
			if (model_combo && &ofs) begin
				model_page  = `CPC_PAGE_COMBO_NEXT;
				model_combo = 1'b0;
			end
		end
	endtask

	////////////////////
	// Host download side

	task automatic start_download(input loader_pkg::dl_index_t idx,
		input loader_pkg::file_ext_t ext);
		@(negedge clk_sys);
		ioctl_index     = idx;
		ioctl_file_ext  = ext;
		ioctl_download  = 1'b1;
		errors_at_start = errors;
		stalls_at_start = stalls;
		test_name = $sformatf("download %0d index %02h ext %s", tests_run, idx, ext);
		model_start(idx, ext);
	endtask

	task automatic send_byte(input loader_pkg::dl_addr_t addr, input mem_pkg::byte_t data);
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		model_byte(addr, data);
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic end_download;
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
		ioctl_download = 1'b0;
		while (writes_done != writes_expected)
			@(negedge clk_sys);                     // Drain queue and memory
		check_value({test_name, " rom_map"}, 256'(expected_map), 256'(rom_map));
		if (ack_min > 0)
			check_value({test_name, " back-pressure"}, 256'(1),
				256'(stalls > stalls_at_start));
		report_test();
	endtask

	////////////////////
	// Memory responder

	initial begin
		int delay;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_req) begin
				if (expected_q.size() == 0) begin
					errors++;
					$display("Unexpected memory write to bank %0d at address %h", mem_bank,
						mem_addr);
				end else begin
					check_value($sformatf("%s write %0d", test_name, writes_done + 1),
						256'(expected_q.pop_front()), 256'({mem_bank, mem_addr, mem_data}));
				end
				delay = ack_min + int'($unsigned($random(seed)) % (ack_max - ack_min + 1));
				repeat (delay) @(negedge clk_sys);
				mem_ack = 1'b1;
				do
					@(negedge clk_sys);
				while (mem_req);
				mem_ack = 1'b0;
				@(negedge clk_sys);
				writes_done++;                           // Page map settled by now
			end
		end
	end

	// Wait runs longer than a dual push mean a held queue
	always @(posedge clk_sys) begin
		cycles++;
		wait_run = ioctl_wait ? wait_run + 1 : 0;
		if (wait_run == 3)
			stalls++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d of %0d memory writes done", cycles,
				writes_done, writes_expected);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_file_ext = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		reset          = 1'b1;
		for (int i = 0; i < MAX_RECORDS; i++)
			records[i] = '0;
		$readmemh("testbench/loader_input.txt", records);
		while (num_records < MAX_RECORDS && records[num_records][47:44] != 4'd0)
			num_records++;
		cycle_limit = 60 * num_records + 200;

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_value("after reset ioctl_wait", 256'(0), 256'(ioctl_wait));
		check_value("after reset mem_req", 256'(0), 256'(mem_req));
		check_value("after reset rom_map", 256'(0), 256'(rom_map));
		report_test();

		for (int i = 0; i < num_records; i++) begin
			case (records[i][47:44])
				4'd1: start_download(records[i][23:16], records[i][15:0]);
				4'd2: send_byte(records[i][40:16], records[i][7:0]);
				4'd3: end_download();
				4'd4: begin
					ack_min = int'(records[i][43:16]);
					ack_max = int'(records[i][15:0]);
				end
				default: begin
					errors++;
					$display("Record %0d of the stimulus file has an unknown kind", i);
				end
			endcase
		end

		$display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpc_loader.f
+incdir+rtl
rtl/loader_pkg.sv
rtl/mem_pkg.sv
rtl/rom_image_loader.sv
rtl/write_queue.sv
rtl/bank_write_port.sv
rtl/cpc_loader_top.sv
testbench/cpc_loader_assertions.sv
testbench/tb_cpc_loader.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cpc_loader
RTL_TOP    := cpc_loader_top
FILELIST   := cpc_loader.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/loader_input.txt
// Record kind_a_b: 1 start (a index, b extension chars), 2 byte (a file address, b data),
// 3 end of download, 4 ack delay (a min cycles, b max cycles)
4_0000000_0005  // acks after 0 to 5 cycles
1_0000000_3030  // base image
2_0000010_00A1  // slot 0, OS 6128
2_0004123_00A2  // slot 1, BASIC
2_000BFFF_00A3  // slot 2, AMSDOS
2_000C001_00A4  // slot 3, MF2
2_0010002_00A5  // slot 4, OS 664
2_0014004_00A6  // slot 5, BASIC 664
2_001F000_00A7  // slot 7, MF2 664
2_0020000_00A8  // slot 8, dropped
3_0000000_0000
1_0000003_3141  // "1A", index 3, both banks
2_0000005_00B1
2_0008010_00B2  // third block, page 1C
3_0000000_0000
1_0000001_5859  // "XY", malformed
2_0004000_00C1  // page EE plus one
3_0000000_0000
1_00000C2_5A5A  // "ZZ", bank 1 only
2_0000100_00D1
3_0000000_0000
4_0000006_000C  // slow memory for back-pressure
1_0000040_5A30  // "Z0", both banks
2_0000000_00E1
2_0003FFF_00E2  // end of first block
2_0004000_00E3  // upper page 00
2_0008001_00E4  // upper page 01
2_0008002_00E5
2_0008003_00E6
3_0000000_0000
